/* filelist.f */
hdl/platform_pkg.sv
hdl/bus_decoder.sv
hdl/data_ram.sv
hdl/machine_timer.sv
hdl/event_channel.sv
hdl/irq_controller.sv
hdl/soc_platform.sv
verification/tb_soc_platform.sv

/* hdl/bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder (
    input  logic                                             clk,
    input  logic                                             reset_i,
    input  logic                                             bus_en_i,
    input  platform_pkg::strobe_t                            bus_we_i,
    input  platform_pkg::addr_t                              bus_addr_i,
    input  platform_pkg::data_t                              ram_rdata_i,
    input  platform_pkg::data_t                              timer_rdata_i,
    input  platform_pkg::data_t                              irq_rdata_i,
    input  platform_pkg::data_t [platform_pkg::NUM_CHANNELS-1:0] chan_rdata_i,
    output logic                                             ram_en_o,
    output logic                                             timer_en_o,
    output logic                                             irq_en_o,
    output logic [platform_pkg::NUM_CHANNELS-1:0]            chan_en_o,
    output platform_pkg::data_t                              bus_rdata_o
);
    import platform_pkg::*;

    logic                    rd_access;
    logic                    sel_ram_q, sel_timer_q, sel_irq_q;
    logic [NUM_CHANNELS-1:0] sel_chan_q;

    assign rd_access = bus_en_i && (bus_we_i == '0);

    // region decode on the top nibble
    always_comb begin
        ram_en_o   = 1'b0;
        timer_en_o = 1'b0;
        irq_en_o   = 1'b0;
        chan_en_o  = '0;
        if (bus_en_i) begin
            if (bus_addr_i[31:28] < REGION_RAM_END) begin
                ram_en_o = 1'b1;
            end else if (bus_addr_i[31:28] < REGION_TIMER_END) begin
                timer_en_o = 1'b1;
            end else if (bus_addr_i[31:28] < REGION_IRQ_END) begin
                irq_en_o = 1'b1;
            end else begin
                for (int i = 0; i < NUM_CHANNELS; i++) begin
                    chan_en_o[i] = (bus_addr_i[7:4] == i);   // out of range hits none
                end
            end
        end
    end

    // remember which slave answers a read
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_ram_q   <= 1'b0;
            sel_timer_q <= 1'b0;
            sel_irq_q   <= 1'b0;
            sel_chan_q  <= '0;
        end else begin
            sel_ram_q   <= ram_en_o && rd_access;
            sel_timer_q <= timer_en_o && rd_access;
            sel_irq_q   <= irq_en_o && rd_access;
            sel_chan_q  <= chan_en_o & {NUM_CHANNELS{rd_access}};
        end
    end

    // one-hot and-or return mux, zero when idle
    always_comb begin
        bus_rdata_o = ({$bits(data_t){sel_ram_q}} & ram_rdata_i)
                    | ({$bits(data_t){sel_timer_q}} & timer_rdata_i)
                    | ({$bits(data_t){sel_irq_q}} & irq_rdata_i);
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            bus_rdata_o = bus_rdata_o | ({$bits(data_t){sel_chan_q[i]}} & chan_rdata_i[i]);
        end
    end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/10ps

module data_ram (
    input  logic                  clk,
    input  logic                  en_i,
    input  platform_pkg::strobe_t we_i,
    input  platform_pkg::addr_t   addr_i,
    input  platform_pkg::data_t   wdata_i,
    output platform_pkg::data_t   rdata_o
);
    import platform_pkg::*;

    data_t                 mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0] word_idx;

    assign word_idx = addr_i[RAM_ADDR_W+1:2];   // byte address to word

    ////////////////////////////////////////
    // byte lanes and registered read
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < $bits(strobe_t); b++) begin
                if (we_i[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
            rdata_o <= mem[word_idx];   // old contents on a write
        end
    end

endmodule

/* hdl/event_channel.sv */
`timescale 1ns/10ps

module event_channel (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  en_i,
    input  platform_pkg::strobe_t we_i,
    input  platform_pkg::addr_t   addr_i,
    input  platform_pkg::data_t   wdata_i,
    input  logic                  ack_i,
    output platform_pkg::data_t   rdata_o,
    output logic                  irq_o
);
    import platform_pkg::*;

    ch_state_t  state_q;
    data_t      reload_q;
    data_t      count_q;
    logic       wr;
    logic [1:0] offset;

    assign wr     = en_i && (we_i != '0);
    assign offset = addr_i[3:2];

    always_ff @(posedge clk) begin
        if (wr && offset == 2'd0) begin
            reload_q <= wdata_i;
        end
    end

    ////////////////////////////////////////
    // countdown fsm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= CH_IDLE;
            count_q <= '0;
            irq_o   <= 1'b0;
        end else begin
            if (ack_i) begin
                irq_o <= 1'b0;   // expiry below overrides
            end
            if (wr && offset == 2'd2) begin
                if (wdata_i[0]) begin
                    state_q <= CH_RUN;
                    count_q <= reload_q;
                end else begin
                    state_q <= CH_IDLE;   // count holds
                end
            end else if (state_q == CH_RUN) begin
                if (count_q == '0) begin
                    count_q <= reload_q;
                    irq_o   <= 1'b1;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (offset)
                2'd0:    rdata_o <= reload_q;
                2'd1:    rdata_o <= count_q;
                2'd2:    rdata_o <= data_t'(state_q == CH_RUN);   // enable bit
                default: rdata_o <= '0;
            endcase
        end
    end

endmodule

/* hdl/irq_controller.sv */
`timescale 1ns/10ps

module irq_controller (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   en_i,
    input  platform_pkg::strobe_t  we_i,
    input  platform_pkg::addr_t    addr_i,
    input  platform_pkg::data_t    wdata_i,
    input  platform_pkg::irq_vec_t irq_i,
    output platform_pkg::data_t    rdata_o,
    output platform_pkg::irq_vec_t ack_o,
    output logic                   mei_o
);
    import platform_pkg::*;

    irq_vec_t   enable_q, pending_q, irq_prev_q;
    irq_vec_t   active, claim_mask, clear_mask;
    data_t      claim_id;
    logic       claim_rd;
    logic [1:0] offset;

    assign offset   = addr_i[3:2];
    assign claim_rd = en_i && (we_i == '0) && (offset == 2'd2);
    assign active   = pending_q & enable_q;

    // lowest id wins, so scan downward and let the last hit stick
    always_comb begin
        claim_id   = '0;
        claim_mask = '0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id   = data_t'(i + 1);
                claim_mask = irq_vec_t'(1) << i;
            end
        end
    end

    assign clear_mask = claim_rd ? claim_mask : '0;

    ////////////////////////////////////////
    // pending, mask and ack
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q   <= '0;
            pending_q  <= '0;
            irq_prev_q <= '0;
            ack_o      <= '0;
            mei_o      <= 1'b0;
        end else begin
            irq_prev_q <= irq_i;
            pending_q  <= (pending_q & ~clear_mask) | (irq_i & ~irq_prev_q);   // rising edges
            ack_o      <= clear_mask;   // one cycle pulse
            mei_o      <= |active;
            if (en_i && (we_i != '0) && offset == 2'd0) begin
                enable_q <= wdata_i[NUM_CHANNELS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (offset)
                2'd0:    rdata_o <= data_t'(enable_q);
                2'd1:    rdata_o <= data_t'(pending_q);
                2'd2:    rdata_o <= claim_id;
                default: rdata_o <= '0;
            endcase
        end
    end

endmodule

/* hdl/machine_timer.sv */
`timescale 1ns/10ps

module machine_timer (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  en_i,
    input  platform_pkg::strobe_t we_i,
    input  platform_pkg::addr_t   addr_i,
    input  platform_pkg::data_t   wdata_i,
    output platform_pkg::data_t   rdata_o,
    output platform_pkg::mtime_t  mtime_o,
    output logic                  mti_o
);
    import platform_pkg::*;

    mtime_t     mtime_q;
    mtime_t     mtimecmp_q;
    logic       wr;
    logic [1:0] offset;

    assign wr     = en_i && (we_i != '0);   // full word on any strobe
    assign offset = addr_i[3:2];

    ////////////////////////////////////////
    // counter and compare
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            mtime_q <= mtime_q + 1'b1;
            if (wr && offset == 2'd2) begin
                mtimecmp_q[31:0] <= wdata_i;
            end
            if (wr && offset == 2'd3) begin
                mtimecmp_q[63:32] <= wdata_i;
            end
        end
    end

    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

    // register read data
    always_ff @(posedge clk) begin
        if (en_i) begin
            case (offset)
                2'd0:    rdata_o <= mtime_q[31:0];
                2'd1:    rdata_o <= mtime_q[63:32];
                2'd2:    rdata_o <= mtimecmp_q[31:0];
                default: rdata_o <= mtimecmp_q[63:32];
            endcase
        end
    end

endmodule

/* hdl/platform_pkg.sv */
package platform_pkg;

    ////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strobe_t;   // one bit per byte lane
    typedef logic [63:0] mtime_t;

    ////////////////////////////////////////
    // interrupt sources
    ////////////////////////////////////////

    localparam int NUM_CHANNELS = 4;   // source ids 1..NUM_CHANNELS

    typedef logic [NUM_CHANNELS-1:0] irq_vec_t;   // bit i is source id i+1

    ////////////////////////////////////////
    // address map
    ////////////////////////////////////////

    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    // upper nibble limits, bits 31:28
    localparam logic [3:0] REGION_RAM_END   = 4'h2;
    localparam logic [3:0] REGION_TIMER_END = 4'h3;
    localparam logic [3:0] REGION_IRQ_END   = 4'h8;   // channels above this

    typedef enum logic {
        CH_IDLE,
        CH_RUN
    } ch_state_t;

endpackage

/* hdl/soc_platform.sv */
`timescale 1ns/10ps

module soc_platform (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  bus_en_i,
    input  platform_pkg::strobe_t bus_we_i,
    input  platform_pkg::addr_t   bus_addr_i,
    input  platform_pkg::data_t   bus_wdata_i,
    output platform_pkg::data_t   bus_rdata_o,
    output platform_pkg::mtime_t  mtime_o,
    output logic                  mti_o,
    output logic                  mei_o
);
    import platform_pkg::*;

    logic                           ram_en, timer_en, irq_en;
    logic [NUM_CHANNELS-1:0]        chan_en;
    data_t                          ram_rdata, timer_rdata, irq_rdata;
    data_t [NUM_CHANNELS-1:0]       chan_rdata;
    irq_vec_t                       irq_req;   // channel to controller
    irq_vec_t                       irq_ack;   // controller back to channel

    ////////////////////////////////////////
    // decode and return path
    ////////////////////////////////////////

    bus_decoder i_bus_decoder (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_en_i      (bus_en_i),
        .bus_we_i      (bus_we_i),
        .bus_addr_i    (bus_addr_i),
        .ram_rdata_i   (ram_rdata),
        .timer_rdata_i (timer_rdata),
        .irq_rdata_i   (irq_rdata),
        .chan_rdata_i  (chan_rdata),
        .ram_en_o      (ram_en),
        .timer_en_o    (timer_en),
        .irq_en_o      (irq_en),
        .chan_en_o     (chan_en),
        .bus_rdata_o   (bus_rdata_o)
    );

    ////////////////////////////////////////
    // slaves
    ////////////////////////////////////////

    data_ram i_data_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (bus_we_i),
        .addr_i  (bus_addr_i),
        .wdata_i (bus_wdata_i),
        .rdata_o (ram_rdata)
    );

    machine_timer i_machine_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .en_i    (timer_en),
        .we_i    (bus_we_i),
        .addr_i  (bus_addr_i),
        .wdata_i (bus_wdata_i),
        .rdata_o (timer_rdata),
        .mtime_o (mtime_o),
        .mti_o   (mti_o)
    );

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        event_channel i_event_channel (
            .clk     (clk),
            .reset_i (reset_i),
            .en_i    (chan_en[g]),
            .we_i    (bus_we_i),
            .addr_i  (bus_addr_i),
            .wdata_i (bus_wdata_i),
            .ack_i   (irq_ack[g]),
            .rdata_o (chan_rdata[g]),
            .irq_o   (irq_req[g])   // source id g+1
        );
    end

    irq_controller i_irq_controller (
        .clk     (clk),
        .reset_i (reset_i),
        .en_i    (irq_en),
        .we_i    (bus_we_i),
        .addr_i  (bus_addr_i),
        .wdata_i (bus_wdata_i),
        .irq_i   (irq_req),
        .rdata_o (irq_rdata),
        .ack_o   (irq_ack),
        .mei_o   (mei_o)
    );

endmodule

/* verification/tb_soc_platform.sv */
`timescale 1ns/10ps

module tb_soc_platform;
    import platform_pkg::*;

    localparam addr_t TIMER_BASE = {REGION_RAM_END, 28'h0};
    localparam addr_t IRQ_BASE   = {REGION_TIMER_END, 28'h0};
    localparam addr_t CHAN_BASE  = {REGION_IRQ_END, 28'h0};
    localparam int    MAX_CYCLES = 4000;

    logic    clk = 1'b0;
    logic    reset_i;
    logic    bus_en_i;
    strobe_t bus_we_i;
    addr_t   bus_addr_i;
    data_t   bus_wdata_i;
    data_t   bus_rdata_o;
    mtime_t  mtime_o;
    logic    mti_o, mei_o;

    int         errors = 0;
    int         checks = 0;
    int         cycle_count = 0;
    logic [31:0] seed = 32'h1778_adb2;
    mtime_t     cmp_model = '1;   // mtimecmp as last written
    data_t      shadow [RAM_WORDS];
    logic [7:0] idx_list [40];

    soc_platform i_soc_platform (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .mtime_o     (mtime_o),
        .mti_o       (mti_o),
        .mei_o       (mei_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // concurrent checks
    ////////////////////////////////////////

    // no access in a cycle means zero read data in the next
    assert property (@(posedge clk) disable iff (reset_i) !bus_en_i |=> bus_rdata_o == '0)
        else begin
            errors++;
            $display("FAILED %0t: read data not zero after an idle cycle", $time);
        end

    assert property (@(posedge clk) disable iff (reset_i) mti_o == (mtime_o >= cmp_model))
        else begin
            errors++;
            $display("FAILED %0t: mti_o disagrees with mtime >= mtimecmp", $time);
        end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // distinct bytes per lane, all taken from the word index
    function automatic data_t fill_pattern(input int word);
        logic [7:0] w;
        w = word[7:0];
        return {w ^ 8'h5a, ~w, w, w ^ 8'ha5};
    endfunction

    task automatic bus_write(input addr_t addr, input data_t data, input strobe_t strb);
        bus_en_i    = 1'b1;
        bus_we_i    = strb;
        bus_addr_i  = addr;
        bus_wdata_i = data;
        @(posedge clk);
        #2;
        bus_en_i = 1'b0;
        bus_we_i = '0;
    endtask

    task automatic bus_read(input addr_t addr, output data_t data);
        bus_en_i   = 1'b1;
        bus_we_i   = '0;
        bus_addr_i = addr;
        @(posedge clk);
        #2;
        bus_en_i = 1'b0;
        data     = bus_rdata_o;   // registered one edge after the access
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_word(input data_t actual, input data_t expected, input string what);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        data_t   rd, rd_prev, wdata;
        strobe_t strb;
        logic [7:0] idx;
        mtime_t  cmp;
        int      tries;
        reset_i     = 1'b1;
        bus_en_i    = 1'b0;
        bus_we_i    = '0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        repeat (3) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // reset values
        check_word(data_t'({mei_o, mti_o}), '0, "mei_o and mti_o after reset");
        check_word(bus_rdata_o, '0, "bus_rdata_o after reset");
        bus_read(TIMER_BASE | 32'h8, rd);
        check_word(rd, '1, "mtimecmp low");
        bus_read(TIMER_BASE | 32'hc, rd);
        check_word(rd, '1, "mtimecmp high");
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            bus_read(CHAN_BASE | addr_t'(c << 4) | 32'h4, rd);
            check_word(rd, '0, $sformatf("channel %0d count", c));
        end
        bus_read(IRQ_BASE, rd);
        check_word(rd, '0, "irq enable mask");
        bus_read(IRQ_BASE | 32'h4, rd);
        check_word(rd, '0, "irq pending");

        // known contents in every lane before the strobed writes
        for (int w = 0; w < RAM_WORDS; w++) begin
            shadow[w] = fill_pattern(w);
            bus_write(addr_t'(w << 2), shadow[w], 4'hf);
        end

        // ram with random lanes
        for (int n = 0; n < 40; n++) begin
            seed = lcg_step(seed);
            idx  = seed[23:16];
            seed = lcg_step(seed);
            wdata = seed;
            seed = lcg_step(seed);
            strb = (seed[27:24] == '0) ? 4'hf : seed[27:24];
            bus_write(addr_t'({idx, 2'b00}), wdata, strb);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            idx_list[n] = idx;
        end
        for (int n = 0; n < 40; n++) begin
            idle_cycles(1);
            check_word(bus_rdata_o, '0, "idle read data before ram read");
            bus_read(addr_t'({idx_list[n], 2'b00}), rd);
            check_word(rd, shadow[idx_list[n]], $sformatf("ram word %0d", idx_list[n]));
        end

        // timer
        bus_read(TIMER_BASE, rd_prev);
        bus_read(TIMER_BASE, rd);
        checks++;
        assert (rd > rd_prev) else begin
            errors++;
            $display("FAILED %0t: mtime did not increase (%0d then %0d)", $time, rd_prev, rd);
        end
        check_word(mtime_o[31:0], rd + 1, "mtime_o low vs read-back");
        check_word(mtime_o[63:32], '0, "mtime_o high");
        cmp = mtime_t'(rd) + 60;
        bus_write(TIMER_BASE | 32'h8, cmp[31:0], 4'hf);
        bus_write(TIMER_BASE | 32'hc, cmp[63:32], 4'hf);
        cmp_model = cmp;
        repeat (50) begin
            check_word(data_t'(mti_o), '0, "mti_o before compare");
            idle_cycles(1);
        end
        idle_cycles(18);   // 70 cycles past the mtime read
        repeat (5) begin
            check_word(data_t'(mti_o), 32'h1, "mti_o after compare");
            idle_cycles(1);
        end

        // channels 1 and 2 expire, source ids 2 and 3
        bus_write(CHAN_BASE | 32'h10, 32'd20, 4'hf);
        bus_write(CHAN_BASE | 32'h20, 32'd20, 4'hf);
        bus_write(CHAN_BASE | 32'h18, 32'h1, 4'hf);
        bus_write(CHAN_BASE | 32'h28, 32'h1, 4'hf);
        rd    = '0;
        tries = 0;
        while (rd != 32'h6 && tries < 30) begin
            bus_read(IRQ_BASE | 32'h4, rd);
            tries++;
        end
        check_word(rd, 32'h6, "pending after expiry");
        idle_cycles(2);
        check_word(data_t'(mei_o), '0, "mei_o while masked");
        bus_write(IRQ_BASE, 32'h6, 4'hf);
        tries = 0;
        while (!mei_o && tries < 5) begin
            idle_cycles(1);
            tries++;
        end
        check_word(data_t'(mei_o), 32'h1, "mei_o after unmask");

        // claims, lowest id first
        bus_write(CHAN_BASE | 32'h18, '0, 4'hf);
        bus_write(CHAN_BASE | 32'h28, '0, 4'hf);
        bus_read(IRQ_BASE | 32'h8, rd);
        check_word(rd, 32'd2, "first claim");
        bus_read(IRQ_BASE | 32'h8, rd);
        check_word(rd, 32'd3, "second claim");
        bus_read(IRQ_BASE | 32'h8, rd);
        check_word(rd, 32'd0, "third claim");
        bus_read(IRQ_BASE | 32'h4, rd);
        check_word(rd, '0, "pending after claims");
        idle_cycles(1);
        check_word(data_t'(mei_o), '0, "mei_o after claims");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
